// File: src/cpu_pkg.sv
/* shared widths, opcodes, alu operations, memory map and core state enum
   for the byte-bus rv32i system */
`default_nettype none

package cpu_pkg;

  typedef logic [31:0] word_t;    // data or instruction word
  typedef logic [17:0] addr_t;    // used part of the byte address bus
  typedef logic [7:0]  byte_t;    // one bus byte
  typedef logic [4:0]  reg_idx_t; // register number

  // arithmetic ops first, branch compares after them
  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor, alu_srl, alu_sra,
    alu_or, alu_and,
    alu_beq, alu_bne, alu_blt, alu_bge, alu_bltu, alu_bgeu
  } alu_op_t;

  // rv32i major opcodes that the core accepts
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_imm    = 7'b0010011; // addi and friends
  localparam logic [6:0] op_reg    = 7'b0110011; // register-register ops

  localparam int ram_addr_bits = 17; // 128 KB

  // i/o region is a[17:16] == 2'b11
  localparam addr_t io_uart_addr = 18'h30000; // write a byte to the uart
  localparam addr_t io_clk_addr  = 18'h30004; // read clock count, write stops

  typedef enum logic [2:0] {
    st_fetch,     // four byte reads of the instruction
    st_decode,    // register file read
    st_execute,   // alu, targets, writeback value
    st_mem,       // byte-serial load or store
    st_writeback  // rd update and pc step
  } core_state_t;

endpackage

`default_nettype wire

// File: src/decoder.sv
/* rv32i instruction decoder: register fields, immediates, alu op and flags */
`timescale 1ns/1ps
`default_nettype none

module decoder (
  input  cpu_pkg::word_t    instr,
  output cpu_pkg::reg_idx_t rs1,
  output cpu_pkg::reg_idx_t rs2,
  output cpu_pkg::reg_idx_t rd,
  output cpu_pkg::word_t    imm,
  output cpu_pkg::alu_op_t  alu_op,
  output logic              use_imm,
  output logic              is_load,
  output logic              is_store,
  output logic              is_branch,
  output logic              is_jal,
  output logic              is_jalr,
  output logic              is_lui,
  output logic              is_auipc,
  output logic              mem_byte,
  output logic              mem_unsigned,
  output logic              writes_rd
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  cpu_pkg::word_t imm_i, imm_s, imm_b, imm_u, imm_j;

  // funct3 plus the alternate bit (instr[30]) to an alu operation
  function automatic cpu_pkg::alu_op_t arith_op(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? cpu_pkg::alu_sub : cpu_pkg::alu_add;
      3'b001:  return cpu_pkg::alu_sll;
      3'b010:  return cpu_pkg::alu_slt;
      3'b011:  return cpu_pkg::alu_sltu;
      3'b100:  return cpu_pkg::alu_xor;
      3'b101:  return alt ? cpu_pkg::alu_sra : cpu_pkg::alu_srl;
      3'b110:  return cpu_pkg::alu_or;
      default: return cpu_pkg::alu_and;
    endcase
  endfunction

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  assign rd     = instr[11:7];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'h000};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  assign mem_byte     = (funct3[1:0] == 2'b00); // lb, lbu, sb
  assign mem_unsigned = funct3[2];              // lbu

  always_comb
  begin
    imm = '0;
    alu_op = cpu_pkg::alu_add; // address adds for loads, stores, jalr
    use_imm = 1'b0;
    is_load = 1'b0;
    is_store = 1'b0;
    is_branch = 1'b0;
    is_jal = 1'b0;
    is_jalr = 1'b0;
    is_lui = 1'b0;
    is_auipc = 1'b0;
    writes_rd = 1'b0;
    case (opcode)
      cpu_pkg::op_lui:
      begin
        imm = imm_u;
        is_lui = 1'b1;
        writes_rd = 1'b1;
      end
      cpu_pkg::op_auipc:
      begin
        imm = imm_u;
        is_auipc = 1'b1;
        writes_rd = 1'b1;
      end
      cpu_pkg::op_jal:
      begin
        imm = imm_j;
        is_jal = 1'b1;
        writes_rd = 1'b1;
      end
      cpu_pkg::op_jalr:
      begin
        imm = imm_i;
        use_imm = 1'b1; // target is rs1 + imm
        is_jalr = 1'b1;
        writes_rd = 1'b1;
      end
      cpu_pkg::op_branch:
      begin
        imm = imm_b;
        is_branch = (funct3[2:1] != 2'b01); // 010 and 011 are undefined
        case (funct3)
          3'b000:  alu_op = cpu_pkg::alu_beq;
          3'b001:  alu_op = cpu_pkg::alu_bne;
          3'b100:  alu_op = cpu_pkg::alu_blt;
          3'b101:  alu_op = cpu_pkg::alu_bge;
          3'b110:  alu_op = cpu_pkg::alu_bltu;
          default: alu_op = cpu_pkg::alu_bgeu;
        endcase
      end
      cpu_pkg::op_load:
      begin
        imm = imm_i;
        use_imm = 1'b1;
        // lb, lw, lbu only; halfwords fall through as no-ops
        is_load = (funct3 == 3'b000) || (funct3 == 3'b010) || (funct3 == 3'b100);
        writes_rd = is_load;
      end
      cpu_pkg::op_store:
      begin
        imm = imm_s;
        use_imm = 1'b1;
        is_store = (funct3 == 3'b000) || (funct3 == 3'b010); // sb, sw
      end
      cpu_pkg::op_imm:
      begin
        imm = imm_i;
        use_imm = 1'b1;
        writes_rd = 1'b1;
        alu_op = arith_op(funct3, (funct3 == 3'b101) && instr[30]); // no subi
      end
      cpu_pkg::op_reg:
      begin
        writes_rd = 1'b1;
        alu_op = arith_op(funct3, instr[30]);
      end
      default: ; // anything else retires as a no-op
    endcase
  end

endmodule

`default_nettype wire

// File: src/alu.sv
/* combinational alu: add/sub, logic, shifts, set-less-than and branch compares */
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  cpu_pkg::alu_op_t op,
  input  cpu_pkg::word_t   a,
  input  cpu_pkg::word_t   b,
  output cpu_pkg::word_t   result,
  output logic             taken
);

  logic [4:0] shamt;
  logic       lt_s;   // signed a < b
  logic       lt_u;   // unsigned a < b

  assign shamt = b[4:0];
  assign lt_s  = $signed(a) < $signed(b);
  assign lt_u  = a < b;

  always_comb
  begin
    result = '0;
    taken = 1'b0;
    case (op)
      cpu_pkg::alu_add:  result = a + b;
      cpu_pkg::alu_sub:  result = a - b;
      cpu_pkg::alu_sll:  result = a << shamt;
      cpu_pkg::alu_slt:  result = {31'b0, lt_s};
      cpu_pkg::alu_sltu: result = {31'b0, lt_u};
      cpu_pkg::alu_xor:  result = a ^ b;
      cpu_pkg::alu_srl:  result = a >> shamt;
      cpu_pkg::alu_sra:  result = cpu_pkg::word_t'($signed(a) >>> shamt);
      cpu_pkg::alu_or:   result = a | b;
      cpu_pkg::alu_and:  result = a & b;
      // compares only drive the branch condition
      cpu_pkg::alu_beq:  taken = (a == b);
      cpu_pkg::alu_bne:  taken = (a != b);
      cpu_pkg::alu_blt:  taken = lt_s;
      cpu_pkg::alu_bge:  taken = !lt_s;
      cpu_pkg::alu_bltu: taken = lt_u;
      cpu_pkg::alu_bgeu: taken = !lt_u;
    endcase
  end

endmodule

`default_nettype wire

// File: src/cpu.sv
/* multi-cycle rv32i core: pc, register file, state machine and the
   byte-serial memory sequencer for fetch, loads and stores */
`timescale 1ns/1ps
`default_nettype none

module cpu (
  input  logic                clk_in,
  input  logic                rst_in,
  input  logic                rdy_in,      // low pauses the whole core
  input  cpu_pkg::byte_t      mem_din,     // read byte, one cycle after its address
  output cpu_pkg::byte_t      mem_dout,
  output cpu_pkg::addr_t      mem_a,
  output logic                mem_wr,
  input  logic                uart_full,   // hold a uart store while high
  output cpu_pkg::word_t      dbgreg_dout
);

  cpu_pkg::core_state_t state;
  cpu_pkg::word_t pc;
  cpu_pkg::word_t next_pc;   // set in execute, taken in writeback
  cpu_pkg::word_t instr;
  cpu_pkg::word_t regs [32];
  cpu_pkg::word_t rs1_val, rs2_val;
  cpu_pkg::word_t res;       // non-load writeback value
  cpu_pkg::word_t mem_buf;   // load bytes shift in at the top, store bytes leave at the bottom
  cpu_pkg::word_t load_val;
  cpu_pkg::word_t wb_val;
  cpu_pkg::addr_t mem_addr;
  logic [2:0] byte_cnt;      // byte position within the current access
  logic [2:0] n_bytes;

  // bus response capture across pauses
  logic rdy_q;               // previous cycle was a ready cycle
  cpu_pkg::byte_t din_hold;  // response to the last ready-cycle read
  cpu_pkg::byte_t din_eff;

  cpu_pkg::reg_idx_t rs1, rs2, rd;
  cpu_pkg::word_t imm;
  cpu_pkg::alu_op_t alu_op;
  logic use_imm, is_load, is_store, is_branch, is_jal, is_jalr;
  logic is_lui, is_auipc, mem_byte, mem_unsigned, writes_rd;
  cpu_pkg::word_t alu_b, alu_result;
  logic taken;

  decoder i_decoder (
    .instr       (instr),
    .rs1         (rs1),
    .rs2         (rs2),
    .rd          (rd),
    .imm         (imm),
    .alu_op      (alu_op),
    .use_imm     (use_imm),
    .is_load     (is_load),
    .is_store    (is_store),
    .is_branch   (is_branch),
    .is_jal      (is_jal),
    .is_jalr     (is_jalr),
    .is_lui      (is_lui),
    .is_auipc    (is_auipc),
    .mem_byte    (mem_byte),
    .mem_unsigned(mem_unsigned),
    .writes_rd   (writes_rd)
  );

  assign alu_b = use_imm ? imm : rs2_val;

  alu i_alu (
    .op    (alu_op),
    .a     (rs1_val),
    .b     (alu_b),
    .result(alu_result),
    .taken (taken)
  );

  assign n_bytes = mem_byte ? 3'd1 : 3'd4;

  // after a pause the live bus byte belongs to the repeated address, so use the held one
  assign din_eff = rdy_q ? mem_din : din_hold;

  always_ff @(posedge clk_in)
  begin
    if (rst_in)
      rdy_q <= 1'b0;
    else
      rdy_q <= rdy_in;
    if (rdy_q)
      din_hold <= mem_din;
  end

  // bus outputs are repeated unchanged while paused
  always_comb
  begin
    case (state)
      cpu_pkg::st_fetch: mem_a = cpu_pkg::addr_t'(pc) + cpu_pkg::addr_t'(byte_cnt);
      cpu_pkg::st_mem:   mem_a = mem_addr + cpu_pkg::addr_t'(byte_cnt);
      default:           mem_a = cpu_pkg::addr_t'(pc);
    endcase
  end

  assign mem_dout = mem_buf[7:0];
  assign mem_wr = rdy_in && (state == cpu_pkg::st_mem) && is_store && !uart_full;

  // lb/lbu byte ends up in the top lane after its single shift
  always_comb
  begin
    if (!mem_byte)
      load_val = mem_buf;
    else if (mem_unsigned)
      load_val = {24'h000000, mem_buf[31:24]};
    else
      load_val = {{24{mem_buf[31]}}, mem_buf[31:24]};
  end

  assign wb_val = is_load ? load_val : res;
  assign dbgreg_dout = regs[10]; // a0

  always_ff @(posedge clk_in)
  begin
    if (rst_in)
    begin
      state <= cpu_pkg::st_fetch;
      pc <= '0;
      byte_cnt <= '0;
      for (int i = 0; i < 32; i++)
        regs[i] <= '0;
    end
    else if (rdy_in)
    begin
      case (state)
        cpu_pkg::st_fetch:
        begin
          if (byte_cnt != 3'd0)
            instr <= {din_eff, instr[31:8]}; // little-endian gather
          if (byte_cnt == 3'd4)
          begin
            byte_cnt <= '0;
            state <= cpu_pkg::st_decode;
          end
          else
            byte_cnt <= byte_cnt + 3'd1;
        end
        cpu_pkg::st_decode:
        begin
          rs1_val <= regs[rs1]; // x0 is never written, reads zero
          rs2_val <= regs[rs2];
          state <= cpu_pkg::st_execute;
        end
        cpu_pkg::st_execute:
        begin
          if (is_lui)
            res <= imm;
          else if (is_auipc)
            res <= pc + imm;
          else if (is_jal || is_jalr)
            res <= pc + 32'd4; // link address
          else
            res <= alu_result;
          if (is_jal || (is_branch && taken))
            next_pc <= pc + imm;
          else if (is_jalr)
            next_pc <= alu_result & ~32'd1;
          else
            next_pc <= pc + 32'd4;
          mem_addr <= cpu_pkg::addr_t'(alu_result);
          mem_buf <= rs2_val; // store data
          byte_cnt <= '0;
          state <= (is_load || is_store) ? cpu_pkg::st_mem : cpu_pkg::st_writeback;
        end
        cpu_pkg::st_mem:
        begin
          if (is_load)
          begin
            if (byte_cnt != 3'd0)
              mem_buf <= {din_eff, mem_buf[31:8]};
            if (byte_cnt == n_bytes)
              state <= cpu_pkg::st_writeback;
            else
              byte_cnt <= byte_cnt + 3'd1;
          end
          else if (!uart_full) // store byte goes out this cycle
          begin
            mem_buf <= {8'h00, mem_buf[31:8]};
            byte_cnt <= byte_cnt + 3'd1;
            if (byte_cnt == n_bytes - 3'd1)
              state <= cpu_pkg::st_writeback;
          end
        end
        cpu_pkg::st_writeback:
        begin
          if (writes_rd && (rd != 5'd0))
            regs[rd] <= wb_val;
          pc <= next_pc;
          byte_cnt <= '0;
          state <= cpu_pkg::st_fetch;
        end
        default: state <= cpu_pkg::st_fetch;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: src/ram.sv
/* 128 KB synchronous byte ram with registered read and a host load port */
`timescale 1ns/1ps
`default_nettype none

module ram (
  input  logic           clk_in,
  input  cpu_pkg::addr_t a,
  input  cpu_pkg::byte_t din,
  input  logic           wr,
  output cpu_pkg::byte_t dout,
  input  logic           load_en,   // host loader, wins over the core
  input  cpu_pkg::addr_t load_a,
  input  cpu_pkg::byte_t load_d
);

  cpu_pkg::byte_t mem [2**cpu_pkg::ram_addr_bits];

  always_ff @(posedge clk_in)
  begin
    if (load_en)
      mem[load_a[cpu_pkg::ram_addr_bits-1:0]] <= load_d;
    else if (wr)
      mem[a[cpu_pkg::ram_addr_bits-1:0]] <= din;
    dout <= mem[a[cpu_pkg::ram_addr_bits-1:0]]; // byte valid next cycle
  end

endmodule

`default_nettype wire

// File: src/io_ctrl.sv
/* memory-mapped i/o: clock counter reads, uart output capture, program stop */
`timescale 1ns/1ps
`default_nettype none

module io_ctrl (
  input  logic           clk_in,
  input  logic           rst_in,
  input  cpu_pkg::addr_t a,
  input  cpu_pkg::byte_t din,
  input  logic           wr,
  input  logic           sel,            // access targets the i/o region
  input  logic           io_buffer_full,
  output cpu_pkg::byte_t dout,
  output logic           uart_full,
  output logic           uart_tx_valid,
  output cpu_pkg::byte_t uart_tx_data,
  output logic           program_done
);

  cpu_pkg::word_t clk_cnt;  // clocks since reset, pauses included
  logic hit_uart;
  logic hit_clk;            // any byte of the clock word

  assign hit_uart = sel && (a == cpu_pkg::io_uart_addr);
  assign hit_clk  = sel && (a[17:2] == cpu_pkg::io_clk_addr[17:2]);

  // address only, so mem_wr can depend on it without a loop
  assign uart_full = hit_uart && io_buffer_full;

  always_ff @(posedge clk_in)
  begin
    if (rst_in)
    begin
      clk_cnt <= '0;
      uart_tx_valid <= 1'b0;
      program_done <= 1'b0;
    end
    else
    begin
      clk_cnt <= clk_cnt + 32'd1;
      uart_tx_valid <= wr && hit_uart && (din != 8'h00); // zero bytes dropped
      if (wr && sel && (a == cpu_pkg::io_clk_addr))
        program_done <= 1'b1; // sticky until reset
    end
  end

  always_ff @(posedge clk_in)
  begin
    if (wr && hit_uart)
      uart_tx_data <= din;
    // uart input is not modelled and reads as zero
    dout <= hit_clk ? clk_cnt[8*a[1:0] +: 8] : 8'h00;
  end

endmodule

`default_nettype wire

// File: src/cpu_soc.sv
/* system top: core, byte ram and i/o block with the read-data return mux */
`timescale 1ns/1ps
`default_nettype none

module cpu_soc (
  input  logic           clk_in,
  input  logic           rst_in,
  input  logic           rdy_in,
  input  logic           io_buffer_full,
  input  logic           load_en,
  input  cpu_pkg::addr_t load_a,
  input  cpu_pkg::byte_t load_d,
  output logic           uart_tx_valid,
  output cpu_pkg::byte_t uart_tx_data,
  output logic           program_done,
  output cpu_pkg::word_t dbgreg_dout
);

  cpu_pkg::addr_t mem_a;
  cpu_pkg::byte_t mem_dout, mem_din, ram_dout, io_dout;
  logic mem_wr, uart_full;
  logic io_sel;    // current access is in the i/o region
  logic io_sel_q;  // which target answers this cycle's read byte

  assign io_sel = (mem_a[17:16] == 2'b11);
  assign mem_din = io_sel_q ? io_dout : ram_dout;

  always_ff @(posedge clk_in)
  begin
    if (rst_in)
      io_sel_q <= 1'b0;
    else
      io_sel_q <= io_sel; // follows the registered read in either target
  end

  cpu i_cpu (
    .clk_in(clk_in), .rst_in(rst_in), .rdy_in(rdy_in),
    .mem_din(mem_din), .mem_dout(mem_dout), .mem_a(mem_a), .mem_wr(mem_wr),
    .uart_full(uart_full), .dbgreg_dout(dbgreg_dout)
  );

  ram i_ram (
    .clk_in(clk_in), .a(mem_a), .din(mem_dout), .wr(mem_wr && !io_sel), .dout(ram_dout),
    .load_en(load_en), .load_a(load_a), .load_d(load_d)
  );

  io_ctrl i_io_ctrl (
    .clk_in(clk_in), .rst_in(rst_in), .a(mem_a), .din(mem_dout), .wr(mem_wr),
    .sel(io_sel), .io_buffer_full(io_buffer_full), .dout(io_dout), .uart_full(uart_full),
    .uart_tx_valid(uart_tx_valid), .uart_tx_data(uart_tx_data), .program_done(program_done)
  );

endmodule

`default_nettype wire

// File: testbench/tb_clock.sv
/* free-running testbench clock, 100 ns period */
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic clk_in
);

  initial
  begin
    clk_in = 1'b0;
    forever
      #50 clk_in = ~clk_in; // half period
  end

endmodule

`default_nettype wire

// File: testbench/tb_cpu_soc.sv
/* testbench for the byte-bus rv32i system: lfsr program generator with an
   isa model, program loader, uart, stop and x10 checks, cycle limit */
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_soc;

  logic           clk_in;
  logic           rst_in;
  logic           rdy_in;
  logic           io_buffer_full;
  logic           load_en;
  cpu_pkg::addr_t load_a;
  cpu_pkg::byte_t load_d;
  logic           uart_tx_valid;
  cpu_pkg::byte_t uart_tx_data;
  logic           program_done;
  cpu_pkg::word_t dbgreg_dout;

  logic [31:0]    lfsr;
  cpu_pkg::word_t prog [$];       // program words, index is pc / 4
  cpu_pkg::word_t mregs [32];     // model register file
  cpu_pkg::byte_t scratch [16];   // model copy of the ram scratch area at 0x8000
  logic [8:0]     exp_uart [$];   // bit 8 set means any nonzero byte
  int             marker;
  int             value_errs;
  int             other_errs;
  logic           full_last;      // io_buffer_full during the previous cycle

  tb_clock i_clock (.clk_in(clk_in));

  cpu_soc i_dut (
    .clk_in(clk_in), .rst_in(rst_in), .rdy_in(rdy_in), .io_buffer_full(io_buffer_full),
    .load_en(load_en), .load_a(load_a), .load_d(load_d),
    .uart_tx_valid(uart_tx_valid), .uart_tx_data(uart_tx_data),
    .program_done(program_done), .dbgreg_dout(dbgreg_dout)
  );

  // fibonacci lfsr, taps 32 22 2 1, one step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic cpu_pkg::reg_idx_t rand_reg();
    return cpu_pkg::reg_idx_t'(1 + take_bits(5) % 28); // x29..x31 stay reserved
  endfunction

  function automatic cpu_pkg::word_t sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  // rv32i arithmetic by funct3, alt is the sub/sra bit
  function automatic cpu_pkg::word_t alu_model(input logic [2:0] f3, input logic alt,
                                               input cpu_pkg::word_t a, input cpu_pkg::word_t b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: return (a < b) ? 32'd1 : 32'd0;
      3'd4: return a ^ b;
      3'd5:
        if (alt)
          return $signed(a) >>> b[4:0];
        else
          return a >> b[4:0];
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_model(input logic [2:0] f3, input cpu_pkg::word_t a,
                                        input cpu_pkg::word_t b);
    case (f3)
      3'b000: return a == b;
      3'b001: return a != b;
      3'b100: return $signed(a) < $signed(b);
      default: return a >= b; // bgeu
    endcase
  endfunction

  function automatic cpu_pkg::word_t i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                            input logic [2:0] f3, input logic [4:0] rd,
                                            input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic cpu_pkg::word_t s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], cpu_pkg::op_store};
  endfunction

  function automatic cpu_pkg::word_t r_type(input logic alt, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] f3,
                                            input logic [4:0] rd);
    return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, cpu_pkg::op_reg};
  endfunction

  function automatic cpu_pkg::word_t b_type(input logic [12:0] off, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], cpu_pkg::op_branch};
  endfunction

  function automatic cpu_pkg::word_t j_type(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, cpu_pkg::op_jal};
  endfunction

  task automatic set_reg(input cpu_pkg::reg_idx_t rd, input cpu_pkg::word_t v);
    if (rd != 5'd0)
      mregs[rd] = v; // x0 stays zero
  endtask

  // each task below appends one instruction and runs it in the model
  task automatic lui_instr(input cpu_pkg::reg_idx_t rd, input logic [19:0] up);
    prog.push_back({up, rd, cpu_pkg::op_lui});
    set_reg(rd, {up, 12'h000});
  endtask

  task automatic imm_op(input logic [2:0] f3, input logic alt, input cpu_pkg::reg_idx_t rd,
                        input cpu_pkg::reg_idx_t rs1, input logic [11:0] imm);
    logic [11:0] field;
    field = imm;
    if (f3 == 3'b001 || f3 == 3'b101)
      field = {1'b0, alt, 5'b0, imm[4:0]}; // shamt plus the sra bit
    prog.push_back(i_type(field, rs1, f3, rd, cpu_pkg::op_imm));
    set_reg(rd, alu_model(f3, alt, mregs[rs1], sext12(field)));
  endtask

  task automatic reg_op(input logic [2:0] f3, input logic alt, input cpu_pkg::reg_idx_t rd,
                        input cpu_pkg::reg_idx_t rs1, input cpu_pkg::reg_idx_t rs2);
    prog.push_back(r_type(alt, rs2, rs1, f3, rd));
    set_reg(rd, alu_model(f3, alt, mregs[rs1], mregs[rs2]));
  endtask

  task automatic store_op(input logic [2:0] f3, input cpu_pkg::reg_idx_t rs2,
                          input cpu_pkg::reg_idx_t rs1, input logic [11:0] imm);
    cpu_pkg::word_t addr;
    int             off;
    addr = mregs[rs1] + sext12(imm);
    off = int'(addr - mregs[31]);
    prog.push_back(s_type(imm, rs2, rs1, f3));
    if (addr == 32'(cpu_pkg::io_uart_addr))
    begin
      if (mregs[rs2][7:0] != 8'h00) // zero writes never reach the uart
        exp_uart.push_back({1'b0, mregs[rs2][7:0]});
    end
    else
      for (int i = 0; i < ((f3 == 3'b010) ? 4 : 1); i++)
        scratch[off + i] = mregs[rs2][8*i +: 8]; // little-endian
  endtask

  task automatic load_op(input logic [2:0] f3, input cpu_pkg::reg_idx_t rd,
                         input cpu_pkg::reg_idx_t rs1, input logic [11:0] imm);
    int             off;
    cpu_pkg::word_t v;
    off = int'(mregs[rs1] + sext12(imm) - mregs[31]);
    prog.push_back(i_type(imm, rs1, f3, rd, cpu_pkg::op_load));
    if (f3 == 3'b010)
      v = {scratch[off+3], scratch[off+2], scratch[off+1], scratch[off]};
    else if (f3 == 3'b100)
      v = {24'h000000, scratch[off]};                 // lbu
    else
      v = {{24{scratch[off][7]}}, scratch[off]};      // lb
    set_reg(rd, v);
  endtask

  // branch over a marker store, the marker shows up only when not taken
  task automatic branch_test(input logic [2:0] f3, input cpu_pkg::reg_idx_t rs1,
                             input cpu_pkg::reg_idx_t rs2);
    logic taken;
    marker++;
    imm_op(3'b000, 1'b0, 5'd29, 5'd0, 12'(marker));
    taken = branch_model(f3, mregs[rs1], mregs[rs2]);
    prog.push_back(b_type(13'd8, rs2, rs1, f3));
    prog.push_back(s_type(12'd0, 5'd29, 5'd30, 3'b000));
    if (!taken)
      exp_uart.push_back(9'(marker));
  endtask

  task automatic jump_test();
    int tgt;
    marker++;
    imm_op(3'b000, 1'b0, 5'd29, 5'd0, 12'(marker));
    prog.push_back(j_type(21'd8, 5'd0));
    prog.push_back(s_type(12'd0, 5'd29, 5'd30, 3'b000)); // jumped over
    marker++;
    imm_op(3'b000, 1'b0, 5'd29, 5'd0, 12'(marker));
    tgt = (prog.size() + 3) * 4;  // past addi, jalr and the marker store
    imm_op(3'b000, 1'b0, 5'd28, 5'd0, 12'(tgt));
    prog.push_back(i_type(12'd0, 5'd28, 3'b000, 5'd1, cpu_pkg::op_jalr));
    set_reg(5'd1, cpu_pkg::word_t'(prog.size() * 4)); // link
    prog.push_back(s_type(12'd0, 5'd29, 5'd30, 3'b000));
  endtask

  task automatic random_block();
    logic [2:0]        f3;
    logic              alt;
    cpu_pkg::reg_idx_t r;
    for (int i = 0; i < 12; i++)
    begin
      f3 = 3'(take_bits(3));
      alt = take_bits(1) != 0;
      if (take_bits(1) != 0)
        reg_op(f3, alt && (f3 == 3'b000 || f3 == 3'b101), rand_reg(), rand_reg(), rand_reg());
      else
        imm_op(f3, alt && (f3 == 3'b101), rand_reg(), rand_reg(), 12'(take_bits(12)));
    end
    for (int i = 0; i < 4; i++)
      store_op(3'b000, rand_reg(), 5'd30, 12'd0); // register low bytes to the uart
    for (int i = 0; i < 2; i++)
      store_op(3'b010, rand_reg(), 5'd31, 12'(4 * take_bits(2)));
    for (int i = 0; i < 2; i++)
      store_op(3'b000, rand_reg(), 5'd31, 12'(take_bits(4)));
    for (int i = 0; i < 3; i++)
    begin
      f3 = (i == 0) ? 3'b000 : (i == 1) ? 3'b010 : 3'b100; // lb, lw, lbu
      r = rand_reg();
      load_op(f3, r, 5'd31, 12'((f3 == 3'b010) ? 4 * take_bits(2) : take_bits(4)));
      store_op(3'b000, r, 5'd30, 12'd0);
      imm_op(3'b101, 1'b0, 5'd28, r, 12'd24);   // top byte shows the extension
      store_op(3'b000, 5'd28, 5'd30, 12'd0);
    end
    for (int i = 0; i < 4; i++)
    begin
      case (take_bits(2))
        0: f3 = 3'b000;
        1: f3 = 3'b001;
        2: f3 = 3'b100;
        default: f3 = 3'b111;
      endcase
      r = rand_reg();
      branch_test(f3, r, (take_bits(1) != 0) ? r : rand_reg());
    end
    jump_test();
  endtask

  task automatic build_program();
    lui_instr(5'd31, 20'h00008); // scratch base 0x8000
    lui_instr(5'd30, 20'h00030); // i/o base 0x30000
    for (int i = 0; i < 4; i++)
      store_op(3'b010, 5'd0, 5'd31, 12'(4 * i));
    for (int i = 1; i <= 28; i++)
    begin
      lui_instr(5'(i), 20'(take_bits(20)));
      imm_op(3'b000, 1'b0, 5'(i), 5'(i), 12'(take_bits(12)));
    end
    for (int b = 0; b < 4; b++)
      random_block();
    // two clock counter reads, their difference goes out as one byte
    prog.push_back(i_type(12'd4, 5'd30, 3'b100, 5'd5, cpu_pkg::op_load));
    prog.push_back(i_type(12'd4, 5'd30, 3'b100, 5'd6, cpu_pkg::op_load));
    prog.push_back(r_type(1'b1, 5'd5, 5'd6, 3'b000, 5'd7));
    prog.push_back(s_type(12'd0, 5'd7, 5'd30, 3'b000));
    exp_uart.push_back(9'h100);
    prog.push_back(s_type(12'd4, 5'd0, 5'd30, 3'b000)); // stop
    prog.push_back(j_type(21'd0, 5'd0));                 // park here
  endtask

  task automatic check_value(input string name, input cpu_pkg::word_t actual,
                             input cpu_pkg::word_t expected);
    if (actual !== expected)
    begin
      value_errs++;
      $display("[ERROR] %0t %s: got %h, expected %h", $time, name, actual, expected);
    end
  endtask

  // uart capture at the falling edge, outputs are settled there
  always @(negedge clk_in)
  begin
    logic [8:0] want;
    if (uart_tx_valid)
    begin
      if (full_last)
      begin
        other_errs++;
        $display("uart byte at %0t was written while io_buffer_full was high", $time);
      end
      if (exp_uart.size() == 0)
      begin
        other_errs++;
        $display("unexpected extra uart byte %h at %0t", uart_tx_data, $time);
      end
      else
      begin
        want = exp_uart.pop_front();
        if (want[8] && uart_tx_data == 8'h00)
        begin
          other_errs++;
          $display("clock difference byte at %0t is zero", $time);
        end
        else if (!want[8])
          check_value("uart_tx_data", 32'(uart_tx_data), 32'(want[7:0]));
      end
    end
    full_last = io_buffer_full;
  end

  initial
  begin
    int             n_bytes;
    int             cyc;
    int             limit;
    cpu_pkg::word_t w;
    lfsr = 32'h1cc9;
    rst_in = 1'b1;
    rdy_in = 1'b0;
    io_buffer_full = 1'b0;
    load_en = 1'b0;
    load_a = '0;
    load_d = '0;
    full_last = 1'b0;
    marker = 0;
    value_errs = 0;
    other_errs = 0;
    for (int i = 0; i < 32; i++)
      mregs[i] = '0;
    build_program();
    n_bytes = prog.size() * 4;
    limit = 40 * prog.size() * 2;
    // one byte per cycle; reset drops after 16 cycles, core paused until loaded
    for (int i = 0; i < n_bytes; i++)
    begin
      @(posedge clk_in);
      #10;
      if (i == 15)
        rst_in = 1'b0;
      w = prog[i / 4];
      load_en = 1'b1;
      load_a = cpu_pkg::addr_t'(i);
      load_d = w[8 * (i % 4) +: 8];
    end
    @(posedge clk_in);
    #10;
    load_en = 1'b0;
    cyc = 0;
    while (!program_done && cyc < limit)
    begin
      rdy_in = (take_bits(2) != 0);          // low a quarter of the time
      io_buffer_full = (take_bits(2) == 3);
      @(posedge clk_in);
      #10;
      cyc++;
    end
    if (program_done)
    begin
      repeat (2) @(posedge clk_in);
      #10;
      check_value("dbgreg_dout", dbgreg_dout, mregs[10]);
      if (exp_uart.size() != 0)
      begin
        other_errs++;
        $display("%0d expected uart bytes never arrived", exp_uart.size());
      end
    end
    else
    begin
      other_errs++;
      $display("timeout: program_done still low after %0d cycles", limit);
    end
    $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
    if (value_errs + other_errs == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: cpu_soc.f
src/cpu_pkg.sv
src/decoder.sv
src/alu.sv
src/cpu.sv
src/ram.sv
src/io_ctrl.sv
src/cpu_soc.sv
testbench/tb_clock.sv
testbench/tb_cpu_soc.sv

// File: run.sh
#!/bin/sh
# build the cpu_soc testbench with verilator, run it and look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f cpu_soc.f --top-module tb_cpu_soc -o sim_cpu_soc

out=$(./obj_dir/sim_cpu_soc)
echo "$out"
if echo "$out" | grep -qx '>>> PASS'; then
  exit 0
fi
exit 1
